//--- srom/srom_image.hex
// One 64-bit ROM word per line, word index 0 first, upper half C0DE0000 plus index
C0DE00003F21FFFF
C0DE00013F21FFFE
C0DE00023F21FFFD
C0DE00033F21FFFC
C0DE00043F21FFFB
C0DE00053F21FFFA
C0DE00063F21FFF9
C0DE00073F21FFF8
C0DE00083F21FFF7
C0DE00093F21FFF6
C0DE000A3F21FFF5
C0DE000B3F21FFF4
C0DE000C3F21FFF3
C0DE000D3F21FFF2
C0DE000E3F21FFF1
C0DE000F3F21FFF0
C0DE00103F21FFEF
C0DE00113F21FFEE
C0DE00123F21FFED
C0DE00133F21FFEC
C0DE00143F21FFEB
C0DE00153F21FFEA
C0DE00163F21FFE9
C0DE00173F21FFE8
C0DE00183F21FFE7
C0DE00193F21FFE6
C0DE001A3F21FFE5
C0DE001B3F21FFE4
C0DE001C3F21FFE3
C0DE001D3F21FFE2
C0DE001E3F21FFE1
C0DE001F3F21FFE0
C0DE00203F21FFDF
C0DE00213F21FFDE
C0DE00223F21FFDD
C0DE00233F21FFDC
C0DE00243F21FFDB
C0DE00253F21FFDA
C0DE00263F21FFD9
C0DE00273F21FFD8
C0DE00283F21FFD7
C0DE00293F21FFD6
C0DE002A3F21FFD5
C0DE002B3F21FFD4
C0DE002C3F21FFD3
C0DE002D3F21FFD2
C0DE002E3F21FFD1
C0DE002F3F21FFD0
C0DE00303F21FFCF
C0DE00313F21FFCE
C0DE00323F21FFCD
C0DE00333F21FFCC
C0DE00343F21FFCB
C0DE00353F21FFCA
C0DE00363F21FFC9
C0DE00373F21FFC8
C0DE00383F21FFC7
C0DE00393F21FFC6
C0DE003A3F21FFC5
C0DE003B3F21FFC4
C0DE003C3F21FFC3
C0DE003D3F21FFC2
C0DE003E3F21FFC1
C0DE003F3F21FFC0

//--- verilog.f
common/srom_pkg.sv
srom/srom_array.sv
srom/ahb_srom.sv
hw/boot_rom_top.sv
testbench/tb_clock_gen.sv
testbench/tb_boot_rom.sv

//--- testbench/tb_boot_rom.sv
// Testbench for the boot ROM top, acting as the single AHB-Lite manager
// Expected responses come from a protocol model and a copy of the image rule

`timescale 1ns/1ps
`default_nettype none

module tb_boot_rom import srom_pkg::*; ();

    // Kind of data phase expected after an accepted address phase
    localparam int KIND_NONE  = 0;
    localparam int KIND_READ  = 1;
    localparam int KIND_ERROR = 2;

    // Traffic is a few hundred cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_READS   = 200;
    localparam int DRIVE_DELAY    = 2;

    logic                  hclk;
    logic                  hreset_n;
    logic                  hsel;
    logic [AHB_ADDR_W-1:0] haddr;
    logic [1:0]            htrans;
    logic                  hwrite;
    logic [AHB_DATA_W-1:0] hwdata;
    logic                  hready;
    logic                  hresp;
    logic [AHB_DATA_W-1:0] hrdata;

    // Expected data phases, pushed on acceptance and popped by the checker
    int   exp_kind_q[$];
    int   exp_idx_q[$];
    logic err_second_due;
    integer seed;
    int   cycle_cnt;

    tb_clock_gen u_clock_gen (
        .hclk_o     (hclk),
        .hreset_n_o (hreset_n)
    );

    boot_rom_top u_dut (
        .hclk     (hclk),
        .hreset_n (hreset_n),
        .hsel_i   (hsel),
        .haddr_i  (haddr),
        .htrans_i (htrans),
        .hwrite_i (hwrite),
        .hwdata_i (hwdata),
        .hready_o (hready),
        .hresp_o  (hresp),
        .hrdata_o (hrdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference model and helpers
    //////////////////////////////////////////////////////////////////////

    // Upper half is C0DE0000 with the index, lower half its inverse
    function automatic logic [AHB_DATA_W-1:0] image_word(input int idx);
        logic [31:0] upper;
        upper = 32'hC0DE_0000 | 32'(idx);
        return {upper, ~upper};
    endfunction

    // Any byte address inside the ROM window
    function automatic logic [AHB_ADDR_W-1:0] window_addr();
        return AHB_ADDR_W'($random(seed) & (SROM_BYTES - 1));
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        $display("CHECK FAILED at %0t ns: %s expected %h actual %h",
                 $time, sig, exp_val, act_val);
        $display("Test failures found");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_response(input logic exp_ready, input logic exp_resp);
        assert (hready === exp_ready)
            else report_mismatch("hready_o", 64'(exp_ready), 64'(hready));
        assert (hresp === exp_resp)
            else report_mismatch("hresp_o", 64'(exp_resp), 64'(hresp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Manager
    //////////////////////////////////////////////////////////////////////

    // Called at a rising edge, returns at the edge that accepts the phase
    // The phase stays on the bus while hready is low
    task automatic bus_cycle(input logic sel, input logic [1:0] trans, input logic write,
                             input logic [AHB_ADDR_W-1:0] addr);
        int kind;
        int idx;
        kind = KIND_NONE;
        idx  = int'(addr >> AHB_BYTE_OFS_W);
        if (sel && (trans == HTRANS_NONSEQ || trans == HTRANS_SEQ)) begin
            if (write || addr >= SROM_BYTES) begin
                kind = KIND_ERROR;
            end else begin
                kind = KIND_READ;
            end
        end
        #DRIVE_DELAY;
        hsel   = sel;
        htrans = trans;
        hwrite = write;
        haddr  = addr;
        hwdata = {$random(seed), $random(seed)};
        @(negedge hclk);
        while (hready !== 1'b1) @(negedge hclk);
        @(posedge hclk);
        exp_kind_q.push_back(kind);
        exp_idx_q.push_back(idx);
    endtask

    // Whole image as one incrementing burst
    task automatic read_image();
        for (int i = 0; i < SROM_DEPTH; i++) begin
            bus_cycle(1'b1, (i == 0) ? HTRANS_NONSEQ : HTRANS_SEQ, 1'b0, AHB_ADDR_W'(i * 8));
        end
        bus_cycle(1'b0, HTRANS_IDLE, 1'b0, '0);
    endtask

    // Reads mixed with IDLE, BUSY and deselected cycles
    task automatic random_traffic(input int n_reads);
        int reads;
        int choice;
        reads = 0;
        while (reads < n_reads) begin
            choice = $unsigned($random(seed)) % 8;
            case (choice)
                0, 1: begin
                    bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, window_addr());
                    reads++;
                end
                2, 3: begin
                    bus_cycle(1'b1, HTRANS_SEQ, 1'b0, window_addr());
                    reads++;
                end
                4: bus_cycle(1'b1, HTRANS_IDLE, 1'b0, window_addr());
                5: bus_cycle(1'b1, HTRANS_BUSY, 1'b0, window_addr());
                // Deselected cycle that may even look like a write
                6: bus_cycle(1'b0, HTRANS_NONSEQ, 1'($random(seed)), window_addr());
                default: bus_cycle(1'b0, HTRANS_IDLE, 1'b0, '0);
            endcase
        end
        bus_cycle(1'b0, HTRANS_IDLE, 1'b0, '0);
    endtask

    task automatic write_attempts();
        // Read queued right behind a write
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 32'h0000_0040);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 32'h0000_0048);
        // Write outside the window, then a SEQ read
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, 32'h0000_0300);
        bus_cycle(1'b1, HTRANS_SEQ, 1'b0, 32'h0000_01F8);
        // Two writes back to back
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, window_addr());
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b1, window_addr());
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, window_addr());
        bus_cycle(1'b0, HTRANS_IDLE, 1'b0, '0);
    endtask

    task automatic out_of_range_reads();
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 32'h0000_0200);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 32'h0000_0000);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 32'hFFFF_FFF8);
        bus_cycle(1'b1, HTRANS_SEQ, 1'b0, 32'h0000_01F8);
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, 32'h0000_0200 + window_addr());
        bus_cycle(1'b1, HTRANS_NONSEQ, 1'b0, window_addr());
        bus_cycle(1'b0, HTRANS_IDLE, 1'b0, '0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checker
    //////////////////////////////////////////////////////////////////////

    // Mid-cycle sampling, well clear of both the edge and the drive delay
    initial begin : response_checker
        int kind;
        int idx;
        err_second_due = 1'b0;
        // First falling edge after the clock has really started
        @(posedge hclk);
        forever begin
            @(negedge hclk);
            if (!hreset_n) begin
                check_response(1'b1, HRESP_OKAY);
                err_second_due = 1'b0;
            end else if (err_second_due) begin
                // Completing cycle of an ERROR response
                check_response(1'b1, HRESP_ERROR);
                err_second_due = 1'b0;
            end else if (exp_kind_q.size() > 0) begin
                kind = exp_kind_q.pop_front();
                idx  = exp_idx_q.pop_front();
                if (kind == KIND_ERROR) begin
                    check_response(1'b0, HRESP_ERROR);
                    err_second_due = 1'b1;
                end else begin
                    check_response(1'b1, HRESP_OKAY);
                    if (kind == KIND_READ) begin
                        assert (hrdata === image_word(idx))
                            else report_mismatch("hrdata_o", image_word(idx), hrdata);
                    end
                end
            end else begin
                // Bus idle
                check_response(1'b1, HRESP_OKAY);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Timeout and test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge hclk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $fatal(1, "simulation timeout");
    end

    initial begin : stimulus
        hsel   = 1'b0;
        haddr  = '0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hwdata = '0;
        seed   = 83;
        @(posedge hreset_n);
        @(posedge hclk);
        read_image();
        random_traffic(RANDOM_READS);
        write_attempts();
        out_of_range_reads();
        repeat (4) bus_cycle(1'b0, HTRANS_IDLE, 1'b0, '0);
        // Let the checker consume the last data phase
        repeat (2) @(posedge hclk);
        if (exp_kind_q.size() != 0 || err_second_due) begin
            $display("Expected responses were still outstanding at the end of the run");
            $display("Test failures found");
            $fatal(1, "responses left unchecked");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Free-running 50 MHz testbench clock with an active-low reset
// Reset covers two rising edges and drops 2 ns after the second one

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic hclk_o,
    output logic hreset_n_o
);

    // 20 ns period
    localparam int HALF_PERIOD   = 10;

    // Rising edges seen with reset asserted
    localparam int RESET_CYCLES  = 2;

    // Same offset the stimulus uses after an edge
    localparam int RELEASE_DELAY = 2;

    initial begin
        hclk_o = 1'b0;
        forever #HALF_PERIOD hclk_o = ~hclk_o;
    end

    initial begin
        hreset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge hclk_o);
        #RELEASE_DELAY;
        hreset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

//--- hw/boot_rom_top.sv
// Boot ROM subsystem top with a single AHB-Lite subordinate
// hreadyout is looped back as hready since no other subordinate shares the bus
// hwdata is accepted on the port but never used

`timescale 1ns/1ps
`default_nettype none

module boot_rom_top import srom_pkg::*; (
    input  logic                  hclk,
    input  logic                  hreset_n,

    // Manager side address and control
    input  logic                  hsel_i,
    input  logic [AHB_ADDR_W-1:0] haddr_i,
    input  logic [1:0]            htrans_i,
    input  logic                  hwrite_i,

    // Write data kept for a complete AHB-Lite port list
    input  logic [AHB_DATA_W-1:0] hwdata_i,

    // Response back to the manager
    output logic                  hready_o,
    output logic                  hresp_o,
    output logic [AHB_DATA_W-1:0] hrdata_o
);

    //////////////////////////////////////////////////////////////////////
    // Internal wiring
    //////////////////////////////////////////////////////////////////////

    // Subordinate ready, also the bus-wide hready
    logic                   hreadyout;

    // Subordinate to ROM
    logic                   rom_cs;
    logic [SROM_ADDR_W-1:0] rom_addr;
    logic [AHB_DATA_W-1:0]  rom_rdata;

    // Single subordinate so its ready is the bus ready
    assign hready_o = hreadyout;

    // hwdata_i is left unconnected because the ROM cannot be written

    //////////////////////////////////////////////////////////////////////
    // AHB-Lite subordinate
    //////////////////////////////////////////////////////////////////////

    ahb_srom u_ahb_srom (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .hsel_i      (hsel_i),
        .hready_i    (hreadyout),
        .htrans_i    (htrans_i),
        .hwrite_i    (hwrite_i),
        .haddr_i     (haddr_i),
        .hreadyout_o (hreadyout),
        .hresp_o     (hresp_o),
        .hrdata_o    (hrdata_o),
        .rom_cs_o    (rom_cs),
        .rom_addr_o  (rom_addr),
        .rom_rdata_i (rom_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // Boot image storage
    //////////////////////////////////////////////////////////////////////

    srom_array u_srom_array (
        .hclk     (hclk),
        .hreset_n (hreset_n),
        .cs_i     (rom_cs),
        .addr_i   (rom_addr),
        .rdata_o  (rom_rdata)
    );

endmodule

`default_nettype wire

//--- srom/ahb_srom.sv
// AHB-Lite read-only subordinate in front of a synchronous ROM
// Zero wait states on good reads, two-cycle ERROR on writes and out-of-window reads
// hsize, hburst, hprot and hmastlock are not looked at

`timescale 1ns/1ps
`default_nettype none

module ahb_srom import srom_pkg::*; (
    input  logic                   hclk,
    input  logic                   hreset_n,

    // AHB-Lite address phase
    input  logic                   hsel_i,
    input  logic                   hready_i,
    input  logic [1:0]             htrans_i,
    input  logic                   hwrite_i,
    input  logic [AHB_ADDR_W-1:0]  haddr_i,

    // AHB-Lite data phase response
    output logic                   hreadyout_o,
    output logic                   hresp_o,
    output logic [AHB_DATA_W-1:0]  hrdata_o,

    // ROM side
    output logic                   rom_cs_o,
    output logic [SROM_ADDR_W-1:0] rom_addr_o,
    input  logic [AHB_DATA_W-1:0]  rom_rdata_i
);

    //////////////////////////////////////////////////////////////////////
    // Address phase decode
    //////////////////////////////////////////////////////////////////////

    logic xfer_valid;
    logic in_window;
    logic bad_xfer;

    // First and second data cycle of an ERROR response
    logic err_first;
    logic err_second;

    // Only NONSEQ and SEQ with the bus ready count as a transfer
    // IDLE and BUSY fall through and see OKAY with ready high
    assign xfer_valid = hsel_i && hready_i &&
                        ((htrans_i == HTRANS_NONSEQ) || (htrans_i == HTRANS_SEQ));

    // Window begins at byte zero of the select region
    assign in_window = (haddr_i < AHB_ADDR_W'(SROM_BYTES));

    // ROM is read-only so any write is an error
    assign bad_xfer = xfer_valid && (hwrite_i || !in_window);

    //////////////////////////////////////////////////////////////////////
    // ROM strobe
    //////////////////////////////////////////////////////////////////////

    // Strobe in the address phase so the word is ready for the data phase
    assign rom_cs_o   = xfer_valid && !hwrite_i && in_window;

    // Drop the byte offset to get the word index
    assign rom_addr_o = haddr_i[AHB_BYTE_OFS_W +: SROM_ADDR_W];

    // ROM output register holds the word through the data phase
    assign hrdata_o   = rom_rdata_i;

    //////////////////////////////////////////////////////////////////////
    // Error sequencing
    //////////////////////////////////////////////////////////////////////

    // err_first marks the stalled cycle
    // err_second is the completing cycle right behind it
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            err_first  <= 1'b0;
            err_second <= 1'b0;
        end else begin
            err_first  <= bad_xfer;
            err_second <= err_first;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////////////////////////

    // Stall only in the first error cycle
    assign hreadyout_o = !err_first;

    // ERROR held for both cycles, OKAY otherwise
    assign hresp_o = (err_first || err_second) ? HRESP_ERROR : HRESP_OKAY;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // ROM data only moves on a strobe, so hrdata holds between reads
    a_rdata_held: assert property (
        @(posedge hclk) disable iff (!hreset_n)
        !$past(rom_cs_o) |-> $stable(rom_rdata_i)
    ) else $error("ahb_srom: ROM data changed without a strobe");

    // A stall never lasts longer than one cycle
    a_no_double_stall: assert property (
        @(posedge hclk) disable iff (!hreadyout_o == 1'b0 && !hreset_n)
        !hreadyout_o |=> hreadyout_o
    ) else $error("ahb_srom: hreadyout low for two cycles");

    // Held address phase must not reach the ROM while stalled
    a_no_cs_in_stall: assert property (
        @(posedge hclk) disable iff (!hreset_n)
        !hreadyout_o |-> !rom_cs_o
    ) else $error("ahb_srom: rom_cs raised during an error stall");

endmodule

`default_nettype wire

//--- srom/srom_array.sv
// Synchronous-read boot ROM with one cycle read latency
// Contents come from srom/srom_image.hex relative to the simulation run directory
// Output register holds its value while cs is low

`timescale 1ns/1ps
`default_nettype none

module srom_array import srom_pkg::*; (
    input  logic                   hclk,
    input  logic                   hreset_n,

    // Read strobe and word index
    input  logic                   cs_i,
    input  logic [SROM_ADDR_W-1:0] addr_i,

    // Registered read data
    output logic [AHB_DATA_W-1:0]  rdata_o
);

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    // One 64-bit word per entry
    logic [AHB_DATA_W-1:0] mem [SROM_DEPTH];

    // Boot image, one hex word per line
    initial begin
        $readmemh("srom/srom_image.hex", mem);
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // Word captured on the strobe edge
    // Reads zero until the first strobe after reset
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            rdata_o <= '0;
        end else if (cs_i) begin
            rdata_o <= mem[addr_i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Strobed index must be fully driven by the subordinate
    a_addr_known: assert property (
        @(posedge hclk) disable iff (!hreset_n)
        cs_i |-> !$isunknown(addr_i)
    ) else $error("srom_array: unknown address with cs high");

endmodule

`default_nettype wire

//--- common/srom_pkg.sv
// Shared sizes and AHB-Lite codes for the boot ROM subsystem
// ROM window starts at byte zero of the select region and spans SROM_BYTES
// Only full 64-bit word transfers exist in this design

`default_nettype none

package srom_pkg;

    //////////////////////////////////////////////////////////////////////
    // AHB-Lite bus widths
    //////////////////////////////////////////////////////////////////////

    // Data bus carries one full ROM word per beat
    localparam int AHB_DATA_W     = 64;

    // Byte address bus
    localparam int AHB_ADDR_W     = 32;

    // Low address bits that pick a byte inside one bus word
    localparam int AHB_BYTE_OFS_W = 3;

    //////////////////////////////////////////////////////////////////////
    // ROM geometry
    //////////////////////////////////////////////////////////////////////

    // Number of 64-bit words in the boot image
    localparam int SROM_DEPTH  = 64;

    // Word index width into the ROM
    localparam int SROM_ADDR_W = 6;

    // Size of the readable window in bytes
    localparam int SROM_BYTES  = SROM_DEPTH * (AHB_DATA_W / 8);

    //////////////////////////////////////////////////////////////////////
    // AHB-Lite encodings
    //////////////////////////////////////////////////////////////////////

    // HTRANS transfer types
    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_BUSY   = 2'b01;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
    localparam logic [1:0] HTRANS_SEQ    = 2'b11;

    // HRESP responses
    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

endpackage

`default_nettype wire
